// File: source/mole_pkg.sv
`default_nettype none

package mole_pkg;

  ////////////////////
  // 640x480 timing
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = 800;
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = 525;
  localparam int H_W      = 10;
  localparam int V_W      = 10;

  ////////////////////
  // board layout, bit order of the holes input
  localparam int NUM_HOLES = 8;
  localparam logic [9:0] HOLE_X [NUM_HOLES] =
    '{10'd100, 10'd250, 10'd400, 10'd175, 10'd325, 10'd100, 10'd250, 10'd400};
  localparam logic [9:0] HOLE_Y [NUM_HOLES] =
    '{10'd100, 10'd100, 10'd100, 10'd225, 10'd225, 10'd350, 10'd350, 10'd350};
  localparam int HOLE_WIDTH  = 75;
  localparam int HOLE_HEIGHT = 10;

  // mole box sits right on top of its bar
  localparam int SPRITE_W     = 64;
  localparam int SPRITE_H     = 52;
  localparam int SPRITE_X_OFS = 5;

  localparam logic [3:0] MOLE_R = 4'd9;
  localparam logic [3:0] MOLE_G = 4'd6;
  localparam logic [3:0] MOLE_B = 4'd2;
  localparam logic [3:0] WHITE  = 4'd15;

  ////////////////////
  // score display, ones digit first
  localparam int SCORE_W = 10;
  localparam logic [9:0] DIGIT_X [3] = '{10'd600, 10'd585, 10'd570};
  localparam int DIGIT_Y = 13;

  // bit 6 top ... bit 1 upper left, bit 0 middle
  function automatic logic [6:0] seg_decode(input logic [3:0] digit);
    case (digit)
      4'd0:    return 7'b1111110;
      4'd1:    return 7'b0110000;
      4'd2:    return 7'b1101101;
      4'd3:    return 7'b1111001;
      4'd4:    return 7'b0110011;
      4'd5:    return 7'b1011011;
      4'd6:    return 7'b1011111;
      4'd7:    return 7'b1110000;
      4'd8:    return 7'b1111111;
      4'd9:    return 7'b1111011;
      default: return 7'b0000000;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/vga_timing.sv
`default_nettype none

module vga_timing (
  input  wire                      in_clk,
  input  wire                      reset,
  output logic [mole_pkg::H_W-1:0] h_count,
  output logic [mole_pkg::V_W-1:0] v_count,
  output logic                     active,
  output logic                     hs,
  output logic                     vs,
  output logic                     frame_end
);

  import mole_pkg::*;

  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int VS_START = V_ACTIVE + V_FRONT;

  logic line_end;

  assign line_end = (h_count == H_TOTAL - 1);

  ////////////////////
  // pixel and line counters
  always_ff @(posedge in_clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      if (v_count == V_TOTAL - 1) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign active = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);

  // both syncs are active low
  assign hs = !((h_count >= HS_START) && (h_count < HS_START + H_SYNC));
  assign vs = !((v_count >= VS_START) && (v_count < VS_START + V_SYNC));

  // last pixel position of the frame, back porch included
  assign frame_end = line_end && (v_count == V_TOTAL - 1);

  a_h_range: assert property (@(posedge in_clk) disable iff (reset)
    h_count < H_TOTAL);

endmodule

`default_nettype wire

// File: source/frame_regs.sv
`default_nettype none

module frame_regs (
  input  wire                              in_clk,
  input  wire                              reset,
  input  wire                              frame_end,
  input  wire  [mole_pkg::NUM_HOLES-1:0]   holes,
  input  wire  [mole_pkg::SCORE_W-1:0]     score,
  output logic [mole_pkg::NUM_HOLES-1:0]   hole_mask,
  output logic [mole_pkg::SCORE_W-1:0]     score_q
);

  // game state is frozen for the whole picture
  always_ff @(posedge in_clk) begin
    if (reset) begin
      hole_mask <= '0;
      score_q   <= '0;
    end else if (frame_end) begin
      hole_mask <= holes;
      score_q   <= score;
    end
  end

  a_frame_only: assert property (@(posedge in_clk) disable iff (reset)
    ($changed(hole_mask) || $changed(score_q)) |-> ($past(frame_end) || $past(reset)));

endmodule

`default_nettype wire

// File: source/mole_sprite.sv
`default_nettype none

module mole_sprite (
  input  wire  [mole_pkg::H_W-1:0]       h_count,
  input  wire  [mole_pkg::V_W-1:0]       v_count,
  input  wire  [mole_pkg::NUM_HOLES-1:0] hole_mask,
  output logic                           mole_hit,
  output logic                           mole_on
);

  import mole_pkg::*;

  logic [SPRITE_W-1:0] rom [SPRITE_H];

  logic [NUM_HOLES-1:0] in_box;
  logic [5:0]           box_row [NUM_HOLES];
  logic [5:0]           box_col [NUM_HOLES];
  logic [5:0]           row;
  logic [5:0]           col;

  initial begin
    $readmemb("source/mole_sprite.mem", rom);
  end

  ////////////////////
  // one box per hole
  for (genvar g = 0; g < NUM_HOLES; g++) begin : g_box
    localparam int LEFT = HOLE_X[g] + SPRITE_X_OFS;
    localparam int TOP  = HOLE_Y[g] - SPRITE_H;

    assign in_box[g] = hole_mask[g] &&
                       (h_count >= LEFT) && (h_count < LEFT + SPRITE_W) &&
                       (v_count >= TOP) && (v_count < HOLE_Y[g]);
    assign box_row[g] = 6'(v_count - TOP);
    assign box_col[g] = 6'(h_count - LEFT);
  end

  // first matching box picks the rom offset
  always_comb begin
    mole_hit = 1'b0;
    row      = '0;
    col      = '0;
    for (int i = 0; i < NUM_HOLES; i++) begin
      if (!mole_hit && in_box[i]) begin
        mole_hit = 1'b1;
        row      = box_row[i];
        col      = box_col[i];
      end
    end
  end

  // column c is bit c of the row word
  assign mole_on = mole_hit && rom[row][col];

endmodule

`default_nettype wire

// File: source/score_overlay.sv
`default_nettype none

module score_overlay (
  input  wire  [mole_pkg::H_W-1:0]     h_count,
  input  wire  [mole_pkg::V_W-1:0]     v_count,
  input  wire  [mole_pkg::SCORE_W-1:0] score_q,
  output logic                         seg_hit,
  output logic                         seg_on
);

  import mole_pkg::*;

  logic [3:0] digit [3];
  logic [2:0] digit_hit;
  logic [2:0] digit_on;
  logic       y_top;
  logic       y_up;
  logic       y_mid;
  logic       y_low;
  logic       y_bot;

  // hundreds of 10 and up decode to blank
  assign digit[0] = 4'(score_q % 10);
  assign digit[1] = 4'((score_q / 10) % 10);
  assign digit[2] = 4'(score_q / 100);

  ////////////////////
  // row bands shared by all digits
  assign y_top = (v_count >= DIGIT_Y)      && (v_count <= DIGIT_Y + 1);
  assign y_up  = (v_count >= DIGIT_Y + 2)  && (v_count <= DIGIT_Y + 11);
  assign y_mid = (v_count >= DIGIT_Y + 12) && (v_count <= DIGIT_Y + 13);
  assign y_low = (v_count >= DIGIT_Y + 14) && (v_count <= DIGIT_Y + 23);
  assign y_bot = (v_count >= DIGIT_Y + 24) && (v_count <= DIGIT_Y + 25);

  for (genvar d = 0; d < 3; d++) begin : g_digit
    localparam int X0 = DIGIT_X[d];

    logic       x_c;
    logic       x_r;
    logic       x_l;
    logic [6:0] rect;
    logic [6:0] seg;

    assign x_c = (h_count >= X0)      && (h_count <= X0 + 9);
    assign x_r = (h_count >= X0 + 10) && (h_count <= X0 + 11);
    assign x_l = (h_count >= X0 - 2)  && (h_count <= X0 - 1);

    // same bit order as seg_decode
    assign rect = {x_c && y_top, x_r && y_up, x_r && y_low, x_c && y_bot,
                   x_l && y_low, x_l && y_up, x_c && y_mid};
    assign seg  = seg_decode(digit[d]);

    assign digit_hit[d] = |rect;
    assign digit_on[d]  = |(rect & seg);
  end

  assign seg_hit = |digit_hit;
  assign seg_on  = |digit_on;

endmodule

`default_nettype wire

// File: source/scene_compose.sv
`default_nettype none

module scene_compose (
  input  wire                    in_clk,
  input  wire                    reset,
  input  wire [mole_pkg::H_W-1:0] h_count,
  input  wire [mole_pkg::V_W-1:0] v_count,
  input  wire                    active,
  input  wire                    hs,
  input  wire                    vs,
  input  wire                    mole_hit,
  input  wire                    mole_on,
  input  wire                    seg_hit,
  input  wire                    seg_on,
  output logic [3:0]             vga_r,
  output logic [3:0]             vga_g,
  output logic [3:0]             vga_b,
  output logic                   vga_hs,
  output logic                   vga_vs
);

  import mole_pkg::*;

  logic       bar_hit;
  logic [3:0] r_nxt;
  logic [3:0] g_nxt;
  logic [3:0] b_nxt;

  always_comb begin
    bar_hit = 1'b0;
    for (int i = 0; i < NUM_HOLES; i++) begin
      if ((h_count >= HOLE_X[i]) && (h_count < HOLE_X[i] + HOLE_WIDTH) &&
          (v_count >= HOLE_Y[i]) && (v_count < HOLE_Y[i] + HOLE_HEIGHT)) begin
        bar_hit = 1'b1;
      end
    end
  end

  ////////////////////
  // layers, later ones win
  always_comb begin
    {r_nxt, g_nxt, b_nxt} = '0;
    if (bar_hit) begin
      {r_nxt, g_nxt, b_nxt} = {WHITE, WHITE, WHITE};
    end
    if (mole_hit) begin
      {r_nxt, g_nxt, b_nxt} = mole_on ? {MOLE_R, MOLE_G, MOLE_B} : 12'h000;
    end
    if (seg_hit) begin
      {r_nxt, g_nxt, b_nxt} = seg_on ? {WHITE, WHITE, WHITE} : 12'h000;
    end
    if (!active) begin
      {r_nxt, g_nxt, b_nxt} = '0;
    end
  end

  // syncs share the color stage so they stay aligned
  always_ff @(posedge in_clk) begin
    if (reset) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      vga_r  <= r_nxt;
      vga_g  <= g_nxt;
      vga_b  <= b_nxt;
      vga_hs <= hs;
      vga_vs <= vs;
    end
  end

endmodule

`default_nettype wire

// File: source/mole_vga_top.sv
`default_nettype none

module mole_vga_top (
  input  wire                            in_clk,
  input  wire                            reset,
  input  wire  [mole_pkg::NUM_HOLES-1:0] holes,
  input  wire  [mole_pkg::SCORE_W-1:0]   score,
  output logic [3:0]                     vga_r,
  output logic [3:0]                     vga_g,
  output logic [3:0]                     vga_b,
  output logic                           vga_hs,
  output logic                           vga_vs
);

  import mole_pkg::*;

  // names below match the sub-block ports
  logic [H_W-1:0]       h_count;
  logic [V_W-1:0]       v_count;
  logic                 active;
  logic                 hs;
  logic                 vs;
  logic                 frame_end;
  logic [NUM_HOLES-1:0] hole_mask;
  logic [SCORE_W-1:0]   score_q;
  logic                 mole_hit;
  logic                 mole_on;
  logic                 seg_hit;
  logic                 seg_on;

  vga_timing u_timing (.*);

  frame_regs u_regs (.*);

  mole_sprite u_sprite (.*);

  score_overlay u_score (.*);

  scene_compose u_compose (.*);

endmodule

`default_nettype wire

// File: bench/tb_mole_vga.sv
`default_nettype none

module tb_mole_vga;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_CYCLES = 800 * 525;
  // reset, then nine frames of tests
  localparam int CYCLE_LIMIT = 4 + 9 * FRAME_CYCLES + 1000;

  localparam int HOLE_XS [8] = '{100, 250, 400, 175, 325, 100, 250, 400};
  localparam int HOLE_YS [8] = '{100, 100, 100, 225, 225, 350, 350, 350};
  localparam int DIGIT_ORG [3] = '{600, 585, 570};
  // segment rectangles, indexed by segment bit
  localparam int SX_LO [7] = '{0, -2, -2, 0, 10, 10, 0};
  localparam int SX_HI [7] = '{9, -1, -1, 9, 11, 11, 9};
  localparam int SY_LO [7] = '{25, 15, 27, 37, 27, 15, 13};
  localparam int SY_HI [7] = '{26, 24, 36, 38, 36, 24, 14};
  localparam logic [6:0] DIGIT_SEGS [10] =
    '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h7B};
  localparam int NEXT_SCORE [4] = '{80, 999, 1023, 0};

  logic        in_clk;
  logic        reset;
  logic [7:0]  holes;
  logic [9:0]  score;
  logic [3:0]  vga_r;
  logic [3:0]  vga_g;
  logic [3:0]  vga_b;
  logic        vga_hs;
  logic        vga_vs;

  logic [63:0] sprite [52];
  logic [15:0] lfsr_state;
  logic [7:0]  mask_m;
  logic [9:0]  score_m;
  logic [13:0] exp_pix;
  logic [13:0] got;
  logic        model_live;
  int          mh;
  int          mv;
  int          exp_h;
  int          exp_v;
  int          cycles;
  int          checks;
  int          mismatches;
  int          vs_low;
  int          tests_run;
  int          tests_failed;

  mole_vga_top dut0 (
    .in_clk (in_clk),
    .reset  (reset),
    .holes  (holes),
    .score  (score),
    .vga_r  (vga_r),
    .vga_g  (vga_g),
    .vga_b  (vga_b),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs)
  );

  always #20 in_clk = ~in_clk;

  ////////////////////
  // reference pixel, {hs, vs, r, g, b}
  function automatic logic [13:0] expected_pixel(input int h, input int v,
                                                 input logic [7:0] mask,
                                                 input logic [9:0] sc);
    logic [11:0] rgb;
    logic [6:0]  segs;
    int          digit [3];
    int          left;
    int          top;
    int          x0;
    rgb = 12'h000;
    if (h < 640 && v < 480) begin
      for (int i = 0; i < 8; i++) begin
        if (h >= HOLE_XS[i] && h < HOLE_XS[i] + 75 && v >= HOLE_YS[i] && v < HOLE_YS[i] + 10) begin
          rgb = 12'hFFF;
        end
      end
      for (int i = 0; i < 8; i++) begin
        left = HOLE_XS[i] + 5;
        top  = HOLE_YS[i] - 52;
        if (mask[i] && h >= left && h < left + 64 && v >= top && v < HOLE_YS[i]) begin
          rgb = sprite[v - top][h - left] ? 12'h962 : 12'h000;
        end
      end
      digit[0] = sc % 10;
      digit[1] = (sc / 10) % 10;
      digit[2] = sc / 100;
      for (int d = 0; d < 3; d++) begin
        if (digit[d] <= 9) begin
          segs = DIGIT_SEGS[digit[d]];
        end else begin
          segs = 7'h00;
        end
        x0 = DIGIT_ORG[d];
        for (int s = 0; s < 7; s++) begin
          if (h >= x0 + SX_LO[s] && h <= x0 + SX_HI[s] && v >= SY_LO[s] && v <= SY_HI[s]) begin
            rgb = segs[s] ? 12'hFFF : 12'h000;
          end
        end
      end
    end
    return {!(h >= 656 && h <= 751), !(v >= 490 && v <= 491), rgb};
  endfunction

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  task automatic wait_at(input int line);
    @(negedge in_clk);
    while (!(mv == line && mh == 0)) begin
      @(negedge in_clk);
    end
  endtask

  // inputs change twice mid-frame, only the last values count
  task automatic show_next(input logic [7:0] next_holes, input logic [9:0] next_score,
                           input logic decoy);
    logic [15:0] r;
    wait_at(100);
    if (decoy) begin
      take_bits(8, r);
      holes = r[7:0];
      take_bits(10, r);
      score = r[9:0];
    end
    wait_at(300);
    holes = next_holes;
    score = next_score;
    wait_at(0);
  endtask

  task automatic report(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  ////////////////////
  // model counters and frame registers
  always @(posedge in_clk) begin
    model_live = 1'b1;
    if (reset) begin
      mh      = 0;
      mv      = 0;
      mask_m  = '0;
      score_m = '0;
      exp_pix = 14'h3000;
    end else begin
      exp_h   = mh;
      exp_v   = mv;
      exp_pix = expected_pixel(mh, mv, mask_m, score_m);
      if (mh == 799 && mv == 524) begin
        mask_m  = holes;
        score_m = score;
      end
      if (mh == 799) begin
        mh = 0;
        mv = (mv == 524) ? 0 : mv + 1;
      end else begin
        mh = mh + 1;
      end
    end
  end

  always @(negedge in_clk) begin
    if (model_live) begin
      checks++;
      got = {vga_hs, vga_vs, vga_r, vga_g, vga_b};
      if (vga_vs === 1'b0) begin
        vs_low++;
      end
      if (got !== exp_pix) begin
        mismatches++;
        if (mismatches <= 20) begin
          $display("FAIL %0t: pixel (%0d,%0d) gave %h, expected %h",
                   $time, exp_h, exp_v, got, exp_pix);
        end
      end
    end
  end

  always @(posedge in_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    logic [15:0] r;
    logic [15:0] s;
    int          n;
    int          len;
    int          errs;
    int          base;
    in_clk       = 1'b0;
    reset        = 1'b1;
    holes        = '0;
    score        = '0;
    lfsr_state   = 16'd53539;
    model_live   = 1'b0;
    exp_pix      = 14'h3000;
    cycles       = 0;
    checks       = 0;
    mismatches   = 0;
    vs_low       = 0;
    tests_run    = 0;
    tests_failed = 0;
    $readmemb("source/mole_sprite.mem", sprite);
    if ((^sprite[0]) === 1'bx) begin
      tests_failed++;
      $display("the sprite file source/mole_sprite.mem could not be read");
    end
    repeat (4) @(negedge in_clk);
    reset = 1'b0;

    // reset values and first hsync pulse
    errs = 0;
    if (vga_hs !== 1'b1 || vga_vs !== 1'b1 || {vga_r, vga_g, vga_b} !== 12'h000) begin
      errs++;
      $display("FAIL %0t: outputs after reset are not sync high and black", $time);
    end
    n = 0;
    while (vga_hs !== 1'b0) begin
      @(negedge in_clk);
      n++;
    end
    len = 0;
    while (vga_hs === 1'b0) begin
      @(negedge in_clk);
      len++;
    end
    if (n != 657) begin
      errs++;
      $display("FAIL %0t: hsync falls after %0d cycles, expected 657", $time, n);
    end
    if (len != 96) begin
      errs++;
      $display("FAIL %0t: hsync low for %0d cycles, expected 96", $time, len);
    end
    report("reset and hsync", errs + mismatches);

    take_bits(10, r);
    show_next(8'hFF, r[9:0], 1'b0);
    errs = mismatches;
    if (vs_low != 2 * 800) begin
      errs++;
      $display("FAIL %0t: vsync low for %0d cycles, expected 1600", $time, vs_low);
    end
    report("empty board frame", errs);

    base = mismatches;
    take_bits(8, r);
    take_bits(10, s);
    show_next(r[7:0], s[9:0], 1'b1);
    report("all moles up", mismatches - base);

    base = mismatches;
    for (int i = 0; i < 3; i++) begin
      take_bits(10, s);
      take_bits(8, r);
      if (i == 1) begin
        s = 16'(1000 + r[4:0] % 24);
      end else if (i == 2) begin
        s = 16'd7;
      end
      show_next(r[7:0], s[9:0], 1'b1);
    end
    report("random frames", mismatches - base);

    // frames showing 7, 80, 999 and 1023
    base = mismatches;
    for (int i = 0; i < 4; i++) begin
      take_bits(8, r);
      show_next(r[7:0], 10'(NEXT_SCORE[i]), 1'b0);
    end
    report("score digits", mismatches - base);

    $display("%0d tests, %0d failed, %0d pixel checks, %0d mismatches",
             tests_run, tests_failed, checks, mismatches);
    if (tests_failed == 0 && mismatches == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/mole_sprite.mem
// rows 0 to 51 from the top, the rightmost digit of a row is column 0
00000000_00000000_00000000_11111111_11111111_00000000_00000000_00000000
00000000_00000000_00001111_11111111_11111111_11110000_00000000_00000000
00000000_00000000_01111111_11111111_11111111_11111110_00000000_00000000
00000000_00000001_11111111_11111111_11111111_11111111_10000000_00000000
00000000_00000111_11111111_11111111_11111111_11111111_11100000_00000000
00000000_00001111_11111111_11111111_11111111_11111111_11110000_00000000
00000000_00011111_11111111_11111111_11111111_11111111_11111000_00000000
00000000_00111111_11111111_11111111_11111111_11111111_11111100_00000000
00000000_00111111_11111111_10000111_11100001_11111111_11111100_00000000
00000000_00111111_11111111_10000111_11100001_11111111_11111100_00000000
00000000_00111111_11111111_10000111_11100001_11111111_11111100_00000000
00000000_01111111_11111111_11111111_11111111_11111111_11111110_00000000
00000000_01111111_11111111_11111111_11111111_11111111_11111110_00000000
00000000_01111111_11111111_11111111_11111111_11111111_11111110_00000000
00000000_11111111_11111111_11111100_00111111_11111111_11111111_00000000
00000000_11111111_11111111_11111100_00111111_11111111_11111111_00000000
00000000_11111111_11111111_11111100_00111111_11111111_11111111_00000000
00000000_11111111_11111111_11111111_11111111_11111111_11111111_00000000
00000000_11111111_11111111_11111111_11111111_11111111_11111111_00000000
00000000_11111111_11111111_11111111_11111111_11111111_11111111_00000000
00000001_11111111_11111111_11000000_00000011_11111111_11111111_10000000
00000001_11111111_11111111_11000000_00000011_11111111_11111111_10000000
00000001_11111111_11111111_11111111_11111111_11111111_11111111_10000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000011_11111111_11111111_11111111_11111111_11111111_11111111_11000000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00000111_11111111_11111111_11111111_11111111_11111111_11111111_11100000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000
00001111_11111111_11111111_11111111_11111111_11111111_11111111_11110000

// File: tb.f
source/mole_pkg.sv
source/vga_timing.sv
source/frame_regs.sv
source/mole_sprite.sv
source/score_overlay.sv
source/scene_compose.sv
source/mole_vga_top.sv
bench/tb_mole_vga.sv

// File: Bender.yml
package:
  name: mole_vga

sources:
  - source/mole_pkg.sv
  - source/vga_timing.sv
  - source/frame_regs.sv
  - source/mole_sprite.sv
  - source/score_overlay.sv
  - source/scene_compose.sv
  - source/mole_vga_top.sv
  - target: test
    files:
      - bench/tb_mole_vga.sv
